// ==== include/conv_consts.svh ====
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// pixel, weight and result width
`define CONV_DWIDTH 32

// word address width of both memory ports
`define CONV_AWIDTH 16

// kernel side, the window is built for three taps per row
`define CONV_WT_DIM 3

// largest feature map side
`define CONV_FM_MAX 16

`endif

// ==== logic/conv_ctrl_pkg.sv ====
package conv_ctrl_pkg;

    // read sequencer
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_load_wt,
        fetch_load_fm,
        fetch_wait_done
    } fetch_state_e;

    // result writer
    typedef enum logic {
        store_idle,
        store_write
    } store_state_e;

    // tag on each streamed word
    typedef enum logic {
        tok_weight,
        tok_pixel
    } token_kind_e;

endpackage

// ==== logic/conv_data_pkg.sv ====
`include "conv_consts.svh"

package conv_data_pkg;

    // pixels, weights and results share one signed word
    typedef logic signed [`CONV_DWIDTH-1:0] pixel_t;

    // sum of products, wraps like the pixel word
    typedef logic signed [`CONV_DWIDTH-1:0] acc_t;

    // word address on the memory ports
    typedef logic [`CONV_AWIDTH-1:0] addr_t;

    // map side length
    typedef logic [7:0] dim_t;

endpackage

// ==== logic/conv_ifs.sv ====
// fetch to window stream
interface conv_token_if;
    import conv_ctrl_pkg::*;
    import conv_data_pkg::*;

    logic        valid;
    logic        ready;
    token_kind_e kind;
    pixel_t      data;

    modport source (output valid, output kind, output data, input ready);
    modport sink (input valid, input kind, input data, output ready);
endinterface

// window to store stream
interface conv_result_if;
    import conv_data_pkg::*;

    logic   valid;
    logic   ready;
    pixel_t data;
    // final output pixel of the map
    logic   last;

    modport source (output valid, output data, output last, input ready);
    modport sink (input valid, input data, input last, output ready);
endinterface

// ==== logic/conv_fetch.sv ====
`include "conv_consts.svh"

module conv_fetch (
    input  logic                  clk,
    input  logic                  write_counter_rst,
    input  logic                  start,
    input  conv_data_pkg::dim_t   fm_dim,
    input  conv_data_pkg::addr_t  wt_offset,
    input  conv_data_pkg::addr_t  ifm_offset,
    output logic                  rd_cyc,
    output logic                  rd_stb,
    output conv_data_pkg::addr_t  rd_adr,
    input  conv_data_pkg::pixel_t rd_dat_r,
    input  logic                  rd_ack,
    conv_token_if.source          tok,
    input  logic                  done,
    output logic                  idle
);
    import conv_ctrl_pkg::*;
    import conv_data_pkg::*;

    localparam int WT_LAST = `CONV_WT_DIM * `CONV_WT_DIM - 1;

    fetch_state_e state;
    logic [3:0]   wt_cnt;
    dim_t         row;
    dim_t         col;
    dim_t         last_idx;
    logic         border;
    logic         slot_free;
    logic         rd_start;
    logic         rd_done;
    logic         halo_load;
    logic         tok_valid;
    token_kind_e  tok_kind;
    pixel_t       tok_data;

    // padded coordinates run 0 .. fm_dim+1
    assign last_idx  = fm_dim + 8'd1;
    assign border    = (row == 8'd0) || (col == 8'd0) || (row == last_idx) || (col == last_idx);
    assign slot_free = !tok_valid || tok.ready;
    assign rd_done   = rd_cyc && rd_ack;
    assign rd_start  = !rd_cyc && slot_free &&
                       ((state == fetch_load_wt) || (state == fetch_load_fm && !border));
    // halo zeros skip memory
    assign halo_load = !rd_cyc && slot_free && (state == fetch_load_fm) && border;

    assign tok.valid = tok_valid;
    assign tok.kind  = tok_kind;
    assign tok.data  = tok_data;
    assign idle      = (state == fetch_idle);

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state     <= fetch_idle;
            rd_cyc    <= 1'b0;
            rd_stb    <= 1'b0;
            tok_valid <= 1'b0;
            wt_cnt    <= '0;
            row       <= '0;
            col       <= '0;
        end else begin
            case (state)
                fetch_idle: begin
                    if (start) begin
                        state  <= fetch_load_wt;
                        wt_cnt <= '0;
                        row    <= '0;
                        col    <= '0;
                    end
                end
                fetch_load_wt: begin
                    if (rd_done) begin
                        wt_cnt <= wt_cnt + 4'd1;
                        if (wt_cnt == 4'(WT_LAST)) begin
                            state <= fetch_load_fm;
                        end
                    end
                end
                fetch_load_fm: begin
                    if (rd_done || halo_load) begin
                        if (col == last_idx) begin
                            col <= '0;
                            row <= row + 8'd1;
                            if (row == last_idx) begin
                                state <= fetch_wait_done;
                            end
                        end else begin
                            col <= col + 8'd1;
                        end
                    end
                end
                fetch_wait_done: begin
                    if (done) begin
                        state <= fetch_idle;
                    end
                end
                default: state <= fetch_idle;
            endcase

            // one word per cycle, bus drops after ack
            if (rd_start) begin
                rd_cyc <= 1'b1;
                rd_stb <= 1'b1;
            end else if (rd_done) begin
                rd_cyc <= 1'b0;
                rd_stb <= 1'b0;
            end

            if (rd_done || halo_load) begin
                tok_valid <= 1'b1;
            end else if (tok.ready) begin
                tok_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_idle && start) begin
            rd_adr <= wt_offset;
        end else if (rd_done) begin
            if (state == fetch_load_wt && wt_cnt == 4'(WT_LAST)) begin
                rd_adr <= ifm_offset;
            end else begin
                rd_adr <= rd_adr + addr_t'(1);
            end
        end

        if (rd_done) begin
            tok_kind <= (state == fetch_load_wt) ? tok_weight : tok_pixel;
            tok_data <= rd_dat_r;
        end else if (halo_load) begin
            tok_kind <= tok_pixel;
            tok_data <= '0;
        end
    end

    // request and address held until the ack
    a_rd_hold: assert property (@(posedge clk) disable iff (write_counter_rst)
        rd_stb && !rd_ack |=> rd_cyc && rd_stb && $stable(rd_adr));

    // held token must not change until the window takes it
    a_tok_hold: assert property (@(posedge clk) disable iff (write_counter_rst)
        tok.valid && !tok.ready |=> tok.valid && $stable(tok.kind) && $stable(tok.data));

endmodule

// ==== logic/conv_window_mac.sv ====
`include "conv_consts.svh"

module conv_window_mac (
    input  logic                clk,
    input  logic                write_counter_rst,
    input  conv_data_pkg::dim_t fm_dim,
    conv_token_if.sink          tok,
    conv_result_if.source       res
);
    import conv_ctrl_pkg::*;
    import conv_data_pkg::*;

    localparam int K      = `CONV_WT_DIM;
    localparam int LB_LEN = `CONV_FM_MAX + 2;
    localparam int LB_AW  = $clog2(LB_LEN);

    pixel_t           wt [K*K];
    logic [3:0]       wt_cnt;
    pixel_t           lb_top [LB_LEN];
    pixel_t           lb_mid [LB_LEN];
    pixel_t           win [K][K];
    pixel_t           nwin [K][K];
    dim_t             row;
    dim_t             col;
    dim_t             last_idx;
    logic [LB_AW-1:0] col_idx;
    logic             take;
    logic             take_wt;
    logic             take_px;
    logic             complete;
    acc_t             acc;
    logic             res_valid;
    pixel_t           res_data;
    logic             res_last;

    assign last_idx  = fm_dim + 8'd1;
    assign col_idx   = col[LB_AW-1:0];
    assign tok.ready = !res_valid || res.ready;
    assign take      = tok.valid && tok.ready;
    assign take_wt   = take && (tok.kind == tok_weight);
    assign take_px   = take && (tok.kind == tok_pixel);
    // window centred on padded (row-1, col-1)
    assign complete  = (row >= 8'd2) && (col >= 8'd2);

    assign res.valid = res_valid;
    assign res.data  = res_data;
    assign res.last  = res_last;

    // shifted window, newest column on the right
    always_comb begin
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K - 1; c++) begin
                nwin[r][c] = win[r][c+1];
            end
        end
        nwin[0][K-1] = lb_top[col_idx];
        nwin[1][K-1] = lb_mid[col_idx];
        nwin[2][K-1] = tok.data;
    end

    always_comb begin
        acc = '0;
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++) begin
                acc = acc + acc_t'(nwin[r][c] * wt[r*K+c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wt_cnt    <= '0;
            row       <= '0;
            col       <= '0;
            res_valid <= 1'b0;
        end else begin
            if (take_wt) begin
                wt_cnt <= wt_cnt + 4'd1;
            end
            if (take_px) begin
                if (col == last_idx) begin
                    col <= '0;
                    if (row == last_idx) begin
                        // map finished, next run reloads weights
                        row    <= '0;
                        wt_cnt <= '0;
                    end else begin
                        row <= row + 8'd1;
                    end
                end else begin
                    col <= col + 8'd1;
                end
            end
            if (take_px && complete) begin
                res_valid <= 1'b1;
            end else if (res.ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_wt) begin
            wt[wt_cnt] <= tok.data;
        end
        if (take_px) begin
            win             <= nwin;
            lb_top[col_idx] <= lb_mid[col_idx];
            lb_mid[col_idx] <= tok.data;
            if (complete) begin
                res_data <= acc;
                res_last <= (row == last_idx) && (col == last_idx);
            end
        end
    end

    a_weights_first: assert property (@(posedge clk) disable iff (write_counter_rst)
        take_px |-> wt_cnt == 4'(K*K));

endmodule

// ==== logic/conv_store.sv ====
module conv_store (
    input  logic                  clk,
    input  logic                  write_counter_rst,
    input  conv_data_pkg::addr_t  ofm_offset,
    conv_result_if.sink           res,
    output logic                  wr_cyc,
    output logic                  wr_stb,
    output logic                  wr_we,
    output conv_data_pkg::addr_t  wr_adr,
    output conv_data_pkg::pixel_t wr_dat_w,
    input  logic                  wr_ack,
    output logic                  done
);
    import conv_ctrl_pkg::*;
    import conv_data_pkg::*;

    localparam int DEPTH = 4;
    localparam int PW    = $clog2(DEPTH);

    store_state_e  state;
    pixel_t        q_data [DEPTH];
    logic          q_last [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          push;
    logic          pop;
    logic          cur_last;
    addr_t         out_cnt;

    assign res.ready = (count != (PW+1)'(DEPTH));
    assign push      = res.valid && res.ready;
    // dequeue as the write cycle opens
    assign pop       = (state == store_idle) && (count != '0);

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state   <= store_idle;
            wr_cyc  <= 1'b0;
            wr_stb  <= 1'b0;
            wr_we   <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end

            case (state)
                store_idle: begin
                    if (pop) begin
                        state  <= store_write;
                        wr_cyc <= 1'b1;
                        wr_stb <= 1'b1;
                        wr_we  <= 1'b1;
                    end
                end
                store_write: begin
                    if (wr_ack) begin
                        state  <= store_idle;
                        wr_cyc <= 1'b0;
                        wr_stb <= 1'b0;
                        wr_we  <= 1'b0;
                        if (cur_last) begin
                            out_cnt <= '0;
                            done    <= 1'b1;
                        end else begin
                            out_cnt <= out_cnt + addr_t'(1);
                        end
                    end
                end
                default: state <= store_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_data[wr_ptr] <= res.data;
            q_last[wr_ptr] <= res.last;
        end
        if (pop) begin
            wr_dat_w <= q_data[rd_ptr];
            cur_last <= q_last[rd_ptr];
            wr_adr   <= ofm_offset + out_cnt;
        end
    end

    // write request, address and data held until the ack
    a_wr_hold: assert property (@(posedge clk) disable iff (write_counter_rst)
        wr_stb && !wr_ack |=> wr_cyc && wr_stb && wr_we &&
                              $stable(wr_adr) && $stable(wr_dat_w));

endmodule

// ==== logic/conv2d_compute.sv ====
module conv2d_compute (
    input  logic                  clk,
    input  logic                  write_counter_rst,

    input  logic                  start,
    output logic                  idle,

    input  conv_data_pkg::dim_t   fm_dim,
    input  conv_data_pkg::addr_t  wt_offset,
    input  conv_data_pkg::addr_t  ifm_offset,
    input  conv_data_pkg::addr_t  ofm_offset,

    // wishbone read master
    output logic                  rd_cyc,
    output logic                  rd_stb,
    output logic                  rd_we,
    output conv_data_pkg::addr_t  rd_adr,
    input  conv_data_pkg::pixel_t rd_dat_r,
    input  logic                  rd_ack,

    // wishbone write master
    output logic                  wr_cyc,
    output logic                  wr_stb,
    output logic                  wr_we,
    output conv_data_pkg::addr_t  wr_adr,
    output conv_data_pkg::pixel_t wr_dat_w,
    input  logic                  wr_ack
);
    logic done;

    conv_token_if  tok_if ();
    conv_result_if res_if ();

    // read port only reads
    assign rd_we = 1'b0;

    conv_fetch fetch0 (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .start             (start),
        .fm_dim            (fm_dim),
        .wt_offset         (wt_offset),
        .ifm_offset        (ifm_offset),
        .rd_cyc            (rd_cyc),
        .rd_stb            (rd_stb),
        .rd_adr            (rd_adr),
        .rd_dat_r          (rd_dat_r),
        .rd_ack            (rd_ack),
        .tok               (tok_if.source),
        .done              (done),
        .idle              (idle)
    );

    conv_window_mac mac0 (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .fm_dim            (fm_dim),
        .tok               (tok_if.sink),
        .res               (res_if.source)
    );

    conv_store store0 (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .ofm_offset        (ofm_offset),
        .res               (res_if.sink),
        .wr_cyc            (wr_cyc),
        .wr_stb            (wr_stb),
        .wr_we             (wr_we),
        .wr_adr            (wr_adr),
        .wr_dat_w          (wr_dat_w),
        .wr_ack            (wr_ack),
        .done              (done)
    );

endmodule

// ==== tests/conv_mem_model.sv ====
`include "conv_consts.svh"

module conv_mem_model (
    input  logic                    clk,
    input  logic                    write_counter_rst,
    input  logic                    rd_cyc,
    input  logic                    rd_stb,
    input  logic                    rd_we,
    input  logic [`CONV_AWIDTH-1:0] rd_adr,
    output logic [`CONV_DWIDTH-1:0] rd_dat_r,
    output logic                    rd_ack,
    input  logic                    wr_cyc,
    input  logic                    wr_stb,
    input  logic                    wr_we,
    input  logic [`CONV_AWIDTH-1:0] wr_adr,
    input  logic [`CONV_DWIDTH-1:0] wr_dat_w,
    output logic                    wr_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`CONV_DWIDTH-1:0] mem [1 << `CONV_AWIDTH];
    logic [15:0]             lfsr;
    logic [1:0]              rd_wait;
    logic [1:0]              wr_wait;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // 0 to 3 wait states, one lfsr step per bit
    function automatic logic [1:0] draw_wait();
        logic [1:0] w;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_next(lfsr);
            w[k] = lfsr[0];
        end
        return w;
    endfunction

    always @(posedge clk) begin
        if (write_counter_rst) begin
            lfsr = 16'd15;
            rd_wait = draw_wait();
            wr_wait = draw_wait();
            rd_ack   <= 1'b0;
            wr_ack   <= 1'b0;
            rd_dat_r <= '0;
        end else begin
            rd_ack <= 1'b0;
            wr_ack <= 1'b0;
            // read port serves only read cycles
            if (rd_cyc && rd_stb && !rd_we && !rd_ack) begin
                if (rd_wait == 2'd0) begin
                    rd_ack   <= 1'b1;
                    rd_dat_r <= mem[rd_adr];
                    rd_wait = draw_wait();
                end else begin
                    rd_wait = rd_wait - 2'd1;
                end
            end
            if (wr_cyc && wr_stb && wr_we && !wr_ack) begin
                if (wr_wait == 2'd0) begin
                    wr_ack      <= 1'b1;
                    mem[wr_adr] = wr_dat_w;
                    wr_wait = draw_wait();
                end else begin
                    wr_wait = wr_wait - 2'd1;
                end
            end
        end
    end

endmodule

// ==== tests/conv2d_compute_tb.sv ====
`include "conv_consts.svh"

module conv2d_compute_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import conv_data_pkg::*;

    localparam addr_t WT_BASE  = 16'h0100;
    localparam addr_t IFM_BASE = 16'h0200;
    localparam addr_t OFM_BASE = 16'h1000;

    logic   clk;
    logic   write_counter_rst;
    logic   start;
    logic   idle;
    dim_t   fm_dim;
    addr_t  wt_offset;
    addr_t  ifm_offset;
    addr_t  ofm_offset;
    logic   rd_cyc;
    logic   rd_stb;
    logic   rd_we;
    addr_t  rd_adr;
    pixel_t rd_dat_r;
    logic   rd_ack;
    logic   wr_cyc;
    logic   wr_stb;
    logic   wr_we;
    addr_t  wr_adr;
    pixel_t wr_dat_w;
    logic   wr_ack;

    string  names[$];
    int     dims[$];
    int     wt_q[$];
    int     in_q[$];
    int     exp_q[$];
    string  words[$];
    int     fd;
    int     limit_cycles = 0;
    int     idle_rises;
    logic   idle_q = 1'b1;

    conv2d_compute dut0 (.*);

    conv_mem_model mem0 (.*);

    always #4 clk = ~clk;

    // count accepted runs by idle rising
    always @(negedge clk) begin
        if (idle && !idle_q) begin
            idle_rises++;
        end
        idle_q = idle;
    end

    function automatic logic [31:0] fill_word(input int a);
        return {~a[15:0], a[15:0]};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Mismatch test=%s expected=%0d actual=%0d", test, expected, actual);
            $display("Something failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic split_line(input string line);
        int  first;
        byte c;
        words.delete();
        first = -1;
        for (int i = 0; i <= line.len(); i++) begin
            c = (i < line.len()) ? line[i] : " ";
            if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
                if (first >= 0) begin
                    words.push_back(line.substr(first, i - 1));
                end
                first = -1;
            end else if (first < 0) begin
                first = i;
            end
        end
    endtask

    // next line holding data, comment lines skipped
    task automatic next_line(output bit ok);
        string line;
        int    rc;
        ok = 1'b0;
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc == 0) begin
                break;
            end
            split_line(line);
            if (words.size() > 0 && words[0][0] != "#") begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic read_row(input int count, input int which);
        bit ok;
        next_line(ok);
        if (!ok || words.size() != count) begin
            stop_run($sformatf("stimulus file: row of %0d numbers missing", count));
        end
        foreach (words[k]) begin
            case (which)
                0: wt_q.push_back(words[k].atoi());
                1: in_q.push_back(words[k].atoi());
                default: exp_q.push_back(words[k].atoi());
            endcase
        end
    endtask

    task automatic read_stimulus();
        bit ok;
        int dim;
        fd = $fopen("tests/conv_stimulus.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open tests/conv_stimulus.txt");
        end
        forever begin
            next_line(ok);
            if (!ok) begin
                break;
            end
            if (words.size() != 3 || words[0] != "test") begin
                stop_run("stimulus file: expected a test line");
            end
            dim = words[2].atoi();
            if (dim < 1 || dim > `CONV_FM_MAX) begin
                stop_run($sformatf("stimulus file: bad map size %0d", dim));
            end
            names.push_back(words[1]);
            dims.push_back(dim);
            read_row(9, 0);
            repeat (dim) read_row(dim, 1);
            repeat (dim) read_row(dim, 2);
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t, input int base);
        string nm;
        int    n;
        addr_t ofm;
        nm  = names[t];
        n   = dims[t];
        ofm = OFM_BASE + addr_t'(t * 256);
        for (int k = 0; k < 9; k++) begin
            mem0.mem[WT_BASE + k] = wt_q[t*9 + k];
        end
        for (int k = 0; k < n * n; k++) begin
            mem0.mem[IFM_BASE + k] = in_q[base + k];
        end

        @(posedge clk);
        #1;
        fm_dim     = dim_t'(n);
        wt_offset  = WT_BASE;
        ifm_offset = IFM_BASE;
        ofm_offset = ofm;
        idle_rises = 0;
        start      = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        check_value({nm, " idle falls"}, 0, int'(idle));

        // second start while busy must be ignored
        repeat (6) @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;

        while (!idle) @(negedge clk);
        repeat (4) @(negedge clk);
        check_value({nm, " idle rises"}, 1, idle_rises);
        check_value({nm, " idle stays"}, 1, int'(idle));

        for (int k = 0; k < n * n; k++) begin
            check_value($sformatf("%s out[%0d]", nm, k), exp_q[base + k],
                        int'(mem0.mem[ofm + k]));
        end
        check_value({nm, " below region"}, int'(fill_word(ofm - 1)),
                    int'(mem0.mem[ofm - 1]));
        for (int k = 0; k < 4; k++) begin
            check_value($sformatf("%s past region +%0d", nm, k),
                        int'(fill_word(ofm + n * n + k)), int'(mem0.mem[ofm + n * n + k]));
        end
    endtask

    initial begin
        int base;
        int total;
        clk               = 1'b0;
        write_counter_rst = 1'b1;
        start             = 1'b0;
        fm_dim            = '0;
        wt_offset         = '0;
        ifm_offset        = '0;
        ofm_offset        = '0;
        for (int a = 0; a < (1 << `CONV_AWIDTH); a++) begin
            mem0.mem[a] = fill_word(a);
        end
        read_stimulus();

        total = 16;
        foreach (dims[t]) begin
            total += ((dims[t] + 2) * (dims[t] + 2) + 9) * 12 + 16;
        end
        limit_cycles = total;

        repeat (16) @(posedge clk);
        #1;
        write_counter_rst = 1'b0;
        @(negedge clk);
        check_value("reset idle", 1, int'(idle));
        check_value("reset rd_cyc", 0, int'(rd_cyc));
        check_value("reset rd_stb", 0, int'(rd_stb));
        check_value("reset rd_we", 0, int'(rd_we));
        check_value("reset wr_cyc", 0, int'(wr_cyc));
        check_value("reset wr_stb", 0, int'(wr_stb));
        check_value("reset wr_we", 0, int'(wr_we));

        base = 0;
        foreach (names[t]) begin
            run_test(t, base);
            base += dims[t] * dims[t];
        end

        $display("Everything OK");
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        stop_run($sformatf("Timeout: run did not finish within %0d cycles", limit_cycles));
    end

endmodule

// ==== build.f ====
+incdir+include
logic/conv_ctrl_pkg.sv
logic/conv_data_pkg.sv
logic/conv_ifs.sv
logic/conv_fetch.sv
logic/conv_window_mac.sv
logic/conv_store.sv
logic/conv2d_compute.sv
tests/conv_mem_model.sv
tests/conv2d_compute_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module conv2d_compute_tb -o conv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/conv_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== tests/conv_stimulus.txt ====
# per test: "test name fm_dim", then 9 kernel weights in row-major order,
# then fm_dim input rows, then fm_dim expected output rows (zero padded)
test ones2x2 2
1 1 1 1 1 1 1 1 1
1 2
3 4
10 10
10 10

test mixed4x4 4
1 0 -1 2 -1 0 0 1 -2
1 2 3 4
5 6 7 8
-1 0 1 2
3 -2 4 -3
-8 -8 -8 10
-8 0 0 11
2 -14 7 4
-3 6 -10 12

test corner3x3 3
0 0 0 0 0 0 0 0 3
1 2 3
4 5 6
7 8 9
15 18 0
24 27 0
0 0 0

test single1x1 1
1 2 3 4 5 6 7 8 9
7
35
